// ==== filelist.f ====
rv32_types.sv
rv32_csr_counter.sv
rv32_csr_alu.sv
rv32_csr_ctrl.sv
rv32_csr.sv
rv32_csr_unit.sv
rv32_csr_checker.sv
rv32_csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module rv32_csr_tb -f filelist.f -o rv32_csr_sim
./obj_dir/rv32_csr_sim > sim.log
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1

// ==== rv32_csr.sv ====
// CSR bank: mscratch, mcountinhibit, cycle and instret counters, read mux and write decode
`timescale 1ns/1ps
`default_nettype none

module rv32_csr (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::rv_csr_id_t          read_id,
    output rv32_types::rv32_word            read_value,
    output logic                            id_known,
    input  rv32_types::csr_write_request_t  write_request,
    input  logic                            instr_retired
);
    import rv32_types::*;

    rv32_word       mscratch;
    rv32_word       next_mscratch;
    mcountinhibit_t mcountinhibit;
    mcountinhibit_t next_mcountinhibit;
    rv64_word       mcycle;
    rv64_word       minstret;
    logic           mcycle_write_low;
    logic           mcycle_write_high;
    logic           minstret_write_low;
    logic           minstret_write_high;

    // Read mux, user shadows alias the machine counters
    always_comb begin
        read_value = '0;
        id_known   = 1'b1;
        case (read_id)
            CSR_MCOUNTINHIBIT: begin
                read_value[MCOUNTINHIBIT_CY_BIT] = mcountinhibit.cy;
                read_value[MCOUNTINHIBIT_IR_BIT] = mcountinhibit.ir;
            end
            CSR_MSCRATCH:              read_value = mscratch;
            CSR_MCYCLE, CSR_CYCLE:     read_value = mcycle[0];
            CSR_MCYCLEH, CSR_CYCLEH:   read_value = mcycle[1];
            CSR_MINSTRET, CSR_INSTRET: read_value = minstret[0];
            CSR_MINSTRETH, CSR_INSTRETH: begin
                read_value = minstret[1];
            end
            default: id_known = 1'b0;
        endcase
    end

    // Write decode into register loads and counter strobes
    always_comb begin
        next_mscratch       = mscratch;
        next_mcountinhibit  = mcountinhibit;
        mcycle_write_low    = 1'b0;
        mcycle_write_high   = 1'b0;
        minstret_write_low  = 1'b0;
        minstret_write_high = 1'b0;
        if (write_request.write) begin
            case (write_request.id)
                CSR_MCOUNTINHIBIT: begin
                    next_mcountinhibit.cy = write_request.value[MCOUNTINHIBIT_CY_BIT];
                    next_mcountinhibit.ir = write_request.value[MCOUNTINHIBIT_IR_BIT];
                end
                CSR_MSCRATCH:  next_mscratch       = write_request.value;
                CSR_MCYCLE:    mcycle_write_low    = 1'b1;
                CSR_MCYCLEH:   mcycle_write_high   = 1'b1;
                CSR_MINSTRET:  minstret_write_low  = 1'b1;
                CSR_MINSTRETH: minstret_write_high = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mscratch      <= '0;
            mcountinhibit <= '0;
        end else begin
            mscratch      <= next_mscratch;
            mcountinhibit <= next_mcountinhibit;
        end
    end

    // Inhibit bits are registered, so a new setting applies from the next edge
    rv32_csr_counter u_mcycle (
        .clk         (clk),
        .resetn      (resetn),
        .inc_enable  (!mcountinhibit.cy),
        .write_low   (mcycle_write_low),
        .write_high  (mcycle_write_high),
        .write_value (write_request.value),
        .count       (mcycle)
    );

    rv32_csr_counter u_minstret (
        .clk         (clk),
        .resetn      (resetn),
        .inc_enable  (instr_retired && !mcountinhibit.ir),
        .write_low   (minstret_write_low),
        .write_high  (minstret_write_high),
        .write_value (write_request.value),
        .count       (minstret)
    );

endmodule

`default_nettype wire

// ==== rv32_csr_alu.sv ====
// CSR ALU: new value from old value and operand for write, set or clear
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_alu (
    input  rv32_types::csr_op_t  op,
    input  rv32_types::rv32_word old_value,
    input  rv32_types::rv32_word operand,
    output rv32_types::rv32_word new_value
);
    import rv32_types::*;

    always_comb begin
        case (op)
            CSR_OP_SET: begin
                new_value = old_value | operand;
            end
            CSR_OP_CLEAR: begin
                // Operand bits that are set get cleared
                new_value = old_value & ~operand;
            end
            default: begin
                new_value = operand;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rv32_csr_checker.sv ====
// CSR unit checker: models the CSR state and compares each result with the expected entry
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_checker (
    input  logic                    clk,
    input  logic                    resetn,
    input  rv32_types::csr_instr_t  instr,
    input  logic                    instr_retired,
    input  rv32_types::csr_result_t result,
    input  int                      test_id,
    input  logic                    exp_from_model,
    input  logic                    exp_illegal,
    input  rv32_types::rv32_word    exp_value,
    output int                      pass_count,
    output int                      fail_count
);
    import rv32_types::*;

    rv32_word       mscratch;
    mcountinhibit_t inhibit;
    logic [63:0]    mcycle;
    logic [63:0]    minstret;
    logic           pending;
    int             pend_id;
    logic           pend_illegal;
    rv32_word       pend_value;

    always @(posedge clk) begin : track
        rv32_word    old_v;
        rv32_word    operand;
        rv32_word    new_v;
        logic        known;
        logic        suppress;
        logic        ill;
        logic [63:0] next_cycle;
        logic [63:0] next_instret;
        if (!resetn) begin
            mscratch = '0;
            inhibit = '0;
            mcycle = '0;
            minstret = '0;
            pending = 1'b0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            // Result of the request sampled one edge earlier
            if (result.valid && !pending) begin
                $display("Result valid arrived with no request outstanding");
                fail_count++;
            end else if (result.valid) begin
                if (result.illegal !== pend_illegal) begin
                    $display("FAILED test %0d: result.illegal expected 0x%0h got 0x%0h",
                             pend_id, pend_illegal, result.illegal);
                end
                if (result.rd_value !== pend_value) begin
                    $display("FAILED test %0d: result.rd_value expected 0x%08h got 0x%08h",
                             pend_id, pend_value, result.rd_value);
                end
                if (result.illegal === pend_illegal && result.rd_value === pend_value) begin
                    $display("test %0d ok: rd_value 0x%08h illegal %0b",
                             pend_id, result.rd_value, result.illegal);
                    pass_count++;
                end else begin
                    fail_count++;
                end
            end

            // Architectural read, cy at bit 0 and ir at bit 2
            known = 1'b1;
            old_v = '0;
            case (instr.id)
                CSR_MCOUNTINHIBIT:         old_v = {29'd0, inhibit.ir, 1'b0, inhibit.cy};
                CSR_MSCRATCH:              old_v = mscratch;
                CSR_MCYCLE, CSR_CYCLE:     old_v = mcycle[31:0];
                CSR_MCYCLEH, CSR_CYCLEH:   old_v = mcycle[63:32];
                CSR_MINSTRET, CSR_INSTRET: old_v = minstret[31:0];
                CSR_MINSTRETH, CSR_INSTRETH: begin
                    old_v = minstret[63:32];
                end
                default: known = 1'b0;
            endcase
            operand = instr.funct3[2] ? {27'd0, instr.src_idx} : instr.rs1_value;
            case (instr.funct3[1:0])
                2'b10:   new_v = old_v | operand;
                2'b11:   new_v = old_v & ~operand;
                default: new_v = operand;
            endcase
            suppress = instr.funct3[1] && (instr.src_idx == 5'd0);
            ill = (instr.funct3[1:0] == 2'b00) || !known
                  || ((instr.id[11:10] == 2'b11) && !suppress);

            pending = instr.valid;
            if (instr.valid) begin
                pend_id = test_id;
                pend_illegal = exp_from_model ? ill : exp_illegal;
                pend_value = exp_from_model ? (ill ? 32'd0 : old_v) : exp_value;
            end

            // Increments use the inhibit bits from before this edge
            next_cycle = mcycle + {63'd0, !inhibit.cy};
            next_instret = minstret + {63'd0, instr_retired && !inhibit.ir};
            if (instr.valid && !ill && !suppress) begin
                case (instr.id)
                    CSR_MCOUNTINHIBIT: begin
                        inhibit.cy = new_v[0];
                        inhibit.ir = new_v[2];
                    end
                    CSR_MSCRATCH:  mscratch = new_v;
                    CSR_MCYCLE:    next_cycle[31:0] = new_v;
                    CSR_MCYCLEH:   next_cycle[63:32] = new_v;
                    CSR_MINSTRET:  next_instret[31:0] = new_v;
                    CSR_MINSTRETH: next_instret[63:32] = new_v;
                    default: ;
                endcase
            end
            mcycle = next_cycle;
            minstret = next_instret;
        end
    end

endmodule

`default_nettype wire

// ==== rv32_csr_counter.sv ====
// 64-bit CSR counter with increment enable and 32-bit half-word writes
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_counter (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 inc_enable,
    input  logic                 write_low,
    input  logic                 write_high,
    input  rv32_types::rv32_word write_value,
    output rv32_types::rv64_word count
);
    import rv32_types::*;

    rv64_word incremented;
    rv64_word next_count;

    // Full 64-bit add so the carry reaches the high half
    assign incremented = inc_enable ? count + 64'd1 : count;

    always_comb begin
        next_count = incremented;
        if (write_low) begin
            next_count[0] = write_value;
        end
        // High half keeps its incremented value unless written
        if (write_high) begin
            next_count[1] = write_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

endmodule

`default_nettype wire

// ==== rv32_csr_ctrl.sv ====
// CSR instruction control: funct3 and address decode, legality check, write issue, result register
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_ctrl (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::csr_instr_t          instr,
    output rv32_types::rv_csr_id_t          read_id,
    input  rv32_types::rv32_word            old_value,
    output rv32_types::csr_op_t             alu_op,
    output rv32_types::rv32_word            operand,
    input  rv32_types::rv32_word            new_value,
    input  logic                            id_known,
    output rv32_types::csr_write_request_t  write_request,
    output rv32_types::csr_result_t         result
);
    import rv32_types::*;

    logic [1:0] op_bits;
    logic       funct3_ok;
    logic       suppress;
    logic       read_only;
    logic       illegal;
    logic       result_valid;
    logic       result_illegal;
    rv32_word   result_rd_value;

    assign op_bits = instr.funct3[1:0];
    assign read_id = instr.id;

    // Immediate forms use the rs1 field as zimm
    assign operand = instr.funct3[2] ? {27'd0, instr.src_idx} : instr.rs1_value;

    always_comb begin
        case (op_bits)
            2'b10:   alu_op = CSR_OP_SET;
            2'b11:   alu_op = CSR_OP_CLEAR;
            default: alu_op = CSR_OP_WRITE;
        endcase
    end

    assign funct3_ok = (op_bits != 2'b00);

    // Set and clear with x0 or zimm 0 only read
    assign suppress = (alu_op != CSR_OP_WRITE) && (instr.src_idx == 5'd0);

    // Top address bits 11 mark the read-only space
    assign read_only = (instr.id[11:10] == 2'b11);
    assign illegal   = !funct3_ok || !id_known || (read_only && !suppress);

    always_comb begin
        write_request.write = instr.valid && !illegal && !suppress;
        write_request.id    = instr.id;
        write_request.value = new_value;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= instr.valid;
        end
    end

    // rd gets the value from before the write edge
    always_ff @(posedge clk) begin
        if (instr.valid) begin
            result_illegal  <= illegal;
            result_rd_value <= illegal ? '0 : old_value;
        end
    end

    assign result = '{valid: result_valid, illegal: result_illegal, rd_value: result_rd_value};

endmodule

`default_nettype wire

// ==== rv32_csr_tb.sv ====
// Testbench for the CSR unit with clock, reset, stimulus table and drive loop
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_tb;
    import rv32_types::*;

    typedef struct packed {
        csr_instr_t instr;
        logic       retire_rnd;
        logic       retire;
        logic       from_model;
        logic       illegal;
        rv32_word   value;
        logic       last;
    } stim_entry_t;

    logic        clk;
    logic        resetn;
    csr_instr_t  instr;
    logic        instr_retired;
    csr_result_t result;
    int          test_id;
    logic        exp_from_model;
    logic        exp_illegal;
    rv32_word    exp_value;
    int          pass_count;
    int          fail_count;
    int          timeouts;
    int          sent;
    int          cycles;
    rv32_word    rnd;
    stim_entry_t stim[$];

    rv32_csr_unit UUT (
        .clk           (clk),
        .resetn        (resetn),
        .instr         (instr),
        .instr_retired (instr_retired),
        .result        (result)
    );

    rv32_csr_checker u_checker (
        .clk            (clk),
        .resetn         (resetn),
        .instr          (instr),
        .instr_retired  (instr_retired),
        .result         (result),
        .test_id        (test_id),
        .exp_from_model (exp_from_model),
        .exp_illegal    (exp_illegal),
        .exp_value      (exp_value),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    always #4 clk = ~clk;

    task automatic push_row(input logic [2:0] f3, input rv_csr_id_t id, input logic [4:0] src,
                            input rv32_word rs1, input logic model, input logic ill,
                            input rv32_word val);
        stim_entry_t e;
        e.instr = '{valid: 1'b1, funct3: f3, id: id, src_idx: src, rs1_value: rs1};
        e.retire_rnd = 1'b1;
        e.retire = 1'b0;
        e.from_model = model;
        e.illegal = ill;
        e.value = val;
        e.last = 1'b0;
        stim.push_back(e);
    endtask

    task automatic fixed_row(input logic [2:0] f3, input rv_csr_id_t id, input logic [4:0] src,
                             input rv32_word rs1, input logic ill, input rv32_word val);
        push_row(f3, id, src, rs1, 1'b0, ill, val);
    endtask

    task automatic model_row(input logic [2:0] f3, input rv_csr_id_t id, input logic [4:0] src,
                             input rv32_word rs1);
        push_row(f3, id, src, rs1, 1'b1, 1'b0, 32'h0);
    endtask

    // Pins instr_retired for the row just added
    task automatic force_retire(input logic value);
        stim_entry_t e;
        e = stim.pop_back();
        e.retire_rnd = 1'b0;
        e.retire = value;
        stim.push_back(e);
    endtask

    // Valid drops after the row that closes a group
    task automatic end_group();
        stim_entry_t e;
        e = stim.pop_back();
        e.last = 1'b1;
        stim.push_back(e);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        instr = '0;
        instr_retired = 1'b0;
        test_id = 0;
        exp_from_model = 1'b0;
        exp_illegal = 1'b0;
        exp_value = '0;
        timeouts = 0;
        sent = 0;
        rnd = $urandom(88);

        // funct3 codes 001 rw, 010 rs, 011 rc, 101 rwi, 110 rsi, 111 rci
        fixed_row(3'b001, CSR_MSCRATCH, 5'd1, 32'hA5A5_0F0F, 1'b0, 32'h0000_0000);
        fixed_row(3'b010, CSR_MSCRATCH, 5'd2, 32'h0000_F000, 1'b0, 32'hA5A5_0F0F);
        fixed_row(3'b011, CSR_MSCRATCH, 5'd3, 32'hA500_0000, 1'b0, 32'hA5A5_FF0F);
        fixed_row(3'b101, CSR_MSCRATCH, 5'h15, 32'hFFFF_FFFF, 1'b0, 32'h00A5_FF0F);
        fixed_row(3'b110, CSR_MSCRATCH, 5'h0A, 32'hFFFF_FFFF, 1'b0, 32'h0000_0015);
        fixed_row(3'b111, CSR_MSCRATCH, 5'h01, 32'hFFFF_FFFF, 1'b0, 32'h0000_001F);
        fixed_row(3'b010, CSR_MSCRATCH, 5'd0, 32'hFFFF_FFFF, 1'b0, 32'h0000_001E);
        fixed_row(3'b011, CSR_MSCRATCH, 5'd0, 32'hFFFF_FFFF, 1'b0, 32'h0000_001E);
        end_group();
        fixed_row(3'b000, CSR_MSCRATCH, 5'd1, 32'h0000_0001, 1'b1, 32'h0);
        fixed_row(3'b100, CSR_MSCRATCH, 5'd1, 32'h0000_0001, 1'b1, 32'h0);
        fixed_row(3'b001, 12'h7C0, 5'd1, 32'h0000_1234, 1'b1, 32'h0);
        fixed_row(3'b001, CSR_CYCLE, 5'd1, 32'h0000_0000, 1'b1, 32'h0);
        fixed_row(3'b010, CSR_MSCRATCH, 5'd0, 32'h0000_0000, 1'b0, 32'h0000_001E);
        model_row(3'b010, CSR_CYCLE, 5'd0, 32'h0);
        end_group();
        model_row(3'b010, CSR_MCYCLEH, 5'd0, 32'h0);
        fixed_row(3'b110, CSR_MCOUNTINHIBIT, 5'd1, 32'h0, 1'b0, 32'h0);
        model_row(3'b010, CSR_MCYCLE, 5'd0, 32'h0);
        model_row(3'b001, CSR_MCYCLE, 5'd1, 32'h1234_5678);
        fixed_row(3'b010, CSR_MCYCLE, 5'd0, 32'h0, 1'b0, 32'h1234_5678);
        fixed_row(3'b010, CSR_CYCLE, 5'd0, 32'h0, 1'b0, 32'h1234_5678);
        fixed_row(3'b111, CSR_MCOUNTINHIBIT, 5'd1, 32'h0, 1'b0, 32'h0000_0001);
        model_row(3'b010, CSR_MCYCLE, 5'd0, 32'h0);
        end_group();
        model_row(3'b010, CSR_MINSTRET, 5'd0, 32'h0);
        model_row(3'b010, CSR_INSTRET, 5'd0, 32'h0);
        fixed_row(3'b110, CSR_MCOUNTINHIBIT, 5'd5, 32'h0, 1'b0, 32'h0);
        fixed_row(3'b010, CSR_MCOUNTINHIBIT, 5'd0, 32'h0, 1'b0, 32'h0000_0005);
        model_row(3'b010, CSR_MINSTRET, 5'd0, 32'h0);
        model_row(3'b001, CSR_MINSTRETH, 5'd1, 32'h0000_ABCD);
        model_row(3'b001, CSR_MINSTRET, 5'd1, 32'hFFFF_FFFE);
        // Retire pulses while ir is set must not move the count
        fixed_row(3'b010, CSR_INSTRETH, 5'd0, 32'h0, 1'b0, 32'h0000_ABCD);
        force_retire(1'b1);
        fixed_row(3'b010, CSR_INSTRET, 5'd0, 32'h0, 1'b0, 32'hFFFF_FFFE);
        force_retire(1'b1);
        fixed_row(3'b111, CSR_MCOUNTINHIBIT, 5'd5, 32'h0, 1'b0, 32'h0000_0005);
        // Two pulses carry the low half into the high half
        model_row(3'b010, CSR_MINSTRET, 5'd0, 32'h0);
        force_retire(1'b1);
        model_row(3'b010, CSR_MINSTRET, 5'd0, 32'h0);
        force_retire(1'b1);
        model_row(3'b010, CSR_MINSTRETH, 5'd0, 32'h0);
        model_row(3'b010, CSR_INSTRETH, 5'd0, 32'h0);
        model_row(3'b010, CSR_CYCLEH, 5'd0, 32'h0);
        end_group();

        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;

        foreach (stim[i]) begin
            rnd = $urandom;
            instr = stim[i].instr;
            instr_retired = stim[i].retire_rnd ? rnd[0] : stim[i].retire;
            test_id = i;
            exp_from_model = stim[i].from_model;
            exp_illegal = stim[i].illegal;
            exp_value = stim[i].value;
            sent++;
            @(posedge clk);
            #1;
            if (stim[i].last) begin
                instr.valid = 1'b0;
                cycles = 0;
                while (pass_count + fail_count < sent && cycles < 10) begin
                    rnd = $urandom;
                    instr_retired = rnd[0];
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                if (pass_count + fail_count < sent) begin
                    $display("No result.valid seen for %0d request(s) up to test %0d",
                             sent - pass_count - fail_count, i);
                    timeouts++;
                end
            end
        end

        $display("Totals: %0d passed, %0d failed, %0d timed out of %0d sent",
                 pass_count, fail_count, timeouts, sent);
        if (fail_count == 0 && timeouts == 0 && pass_count == sent) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv32_csr_unit.sv ====
// CSR unit top: control, ALU and register bank
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_unit (
    input  logic                   clk,
    input  logic                   resetn,
    input  rv32_types::csr_instr_t instr,
    input  logic                   instr_retired,
    output rv32_types::csr_result_t result
);
    import rv32_types::*;

    rv_csr_id_t         read_id;
    rv32_word           old_value;
    csr_op_t            alu_op;
    rv32_word           operand;
    rv32_word           new_value;
    logic               id_known;
    csr_write_request_t write_request;

    rv32_csr_ctrl u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .instr         (instr),
        .read_id       (read_id),
        .old_value     (old_value),
        .alu_op        (alu_op),
        .operand       (operand),
        .new_value     (new_value),
        .id_known      (id_known),
        .write_request (write_request),
        .result        (result)
    );

    rv32_csr_alu u_alu (
        .op        (alu_op),
        .old_value (old_value),
        .operand   (operand),
        .new_value (new_value)
    );

    rv32_csr u_csr (
        .clk           (clk),
        .resetn        (resetn),
        .read_id       (read_id),
        .read_value    (old_value),
        .id_known      (id_known),
        .write_request (write_request),
        .instr_retired (instr_retired)
    );

endmodule

`default_nettype wire

// ==== rv32_types.sv ====
// Shared RV32 CSR types: data words, CSR addresses, operations and request/result structs
`default_nettype none

package rv32_types;

    typedef logic [31:0] rv32_word;

    // Index 1 is the high half, index 0 the low half
    typedef rv32_word [1:0] rv64_word;

    typedef logic [11:0] rv_csr_id_t;

    // Machine-mode CSRs
    localparam rv_csr_id_t CSR_MCOUNTINHIBIT = 12'h320;
    localparam rv_csr_id_t CSR_MSCRATCH      = 12'h340;
    localparam rv_csr_id_t CSR_MCYCLE        = 12'hB00;
    localparam rv_csr_id_t CSR_MCYCLEH       = 12'hB80;
    localparam rv_csr_id_t CSR_MINSTRET      = 12'hB02;
    localparam rv_csr_id_t CSR_MINSTRETH     = 12'hB82;

    // User read-only shadows
    localparam rv_csr_id_t CSR_CYCLE         = 12'hC00;
    localparam rv_csr_id_t CSR_CYCLEH        = 12'hC80;
    localparam rv_csr_id_t CSR_INSTRET       = 12'hC02;
    localparam rv_csr_id_t CSR_INSTRETH      = 12'hC82;

    // Encoded like funct3[1:0]
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] funct3;
        rv_csr_id_t id;
        logic [4:0] src_idx;
        rv32_word   rs1_value;
    } csr_instr_t;

    typedef struct packed {
        logic       write;
        rv_csr_id_t id;
        rv32_word   value;
    } csr_write_request_t;

    typedef struct packed {
        logic     valid;
        logic     illegal;
        rv32_word rd_value;
    } csr_result_t;

    typedef struct packed {
        logic cy;
        logic ir;
    } mcountinhibit_t;

    // Architectural bit positions inside mcountinhibit
    localparam int MCOUNTINHIBIT_CY_BIT = 0;
    localparam int MCOUNTINHIBIT_IR_BIT = 2;

endpackage

`default_nettype wire
